//--- Bender.yml
package:
  name: packet_buffer

sources:
  - files:
      - common/packet_pkg.sv
      - packet_descriptor_fifo/fifo_core.sv
      - packet_descriptor_fifo/packet_descriptor_fifo.sv
      - verilog/packet_ingress.sv
      - verilog/packet_buffer_mem.sv
      - verilog/packet_egress.sv
      - verilog/packet_buffer.sv
  - target: test
    files:
      - verification/packet_buffer_checker.sv
      - verification/packet_buffer_tb.sv

//--- common/packet_pkg.sv
package packet_pkg;

    // One 32-bit beat of packet payload.
    typedef logic [31:0] data_t;

    // Word address into the shared buffer; 8 bits covers up to 256 words.
    typedef logic [7:0] addr_t;

    // Packet length counted in beats.
    typedef logic [7:0] size_t;

    // User metadata that travels with a packet.
    typedef logic [15:0] meta_t;

    // Descriptor issued by ingress once a packet is fully stored.
    // The addr field points at the first beat of the packet in the buffer.
    typedef struct packed {
        addr_t addr;
        size_t size;
        meta_t meta;
        logic  err;
    } packet_descriptor_t;

    // Stream beat used on both the input and the output side.
    // On output, meta and err repeat the descriptor values on every beat.
    typedef struct packed {
        data_t data;
        meta_t meta;
        logic  last;
        logic  err;
    } beat_t;

endpackage : packet_pkg

//--- compile.f
common/packet_pkg.sv
packet_descriptor_fifo/fifo_core.sv
packet_descriptor_fifo/packet_descriptor_fifo.sv
verilog/packet_ingress.sv
verilog/packet_buffer_mem.sv
verilog/packet_egress.sv
verilog/packet_buffer.sv
verification/packet_buffer_checker.sv
verification/packet_buffer_tb.sv

//--- packet_descriptor_fifo/fifo_core.sv
`timescale 1ns/1ps

module fifo_core #(
    parameter type DATA_T = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  logic  clk,
    input  logic  arst_n,
    input  DATA_T wr_data,
    input  logic  wr,
    output logic  wr_rdy,
    output DATA_T rd_data,
    output logic  rd_ack,
    input  logic  rd
);

    localparam int AW = $clog2(DEPTH);

    // The extra pointer bit separates the full case from the empty case.
    typedef logic [AW:0] ptr_t;

    DATA_T entries [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    logic  empty;
    logic  full;
    logic  do_write;
    logic  do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // A full FIFO refuses a write even when a read happens in the same cycle.
    assign wr_rdy   = !full;
    assign rd_ack   = !empty;
    assign do_write = wr && wr_rdy;
    assign do_read  = rd && rd_ack;

    // First-word-fall-through: the head entry is visible without a read request.
    assign rd_data = entries[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            entries[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule : fifo_core

//--- packet_descriptor_fifo/packet_descriptor_fifo.sv
`timescale 1ns/1ps

module packet_descriptor_fifo
    import packet_pkg::*;
#(
    parameter int DESC_DEPTH = 8
) (
    input  logic               clk,
    input  logic               arst_n,
    input  packet_descriptor_t desc,
    input  logic               desc_valid,
    output logic               desc_rdy,
    output packet_descriptor_t fifo_desc,
    output logic               fifo_valid,
    input  logic               fifo_rdy
);

    // The pointer scheme in fifo_core needs a power-of-two depth of at least two.
    if ((DESC_DEPTH < 2) || ((DESC_DEPTH & (DESC_DEPTH - 1)) != 0)) begin : g_bad_depth
        $error("DESC_DEPTH must be a power of two and at least 2");
    end

    // Typed descriptor queue between the ingress producer and the egress consumer.
    fifo_core #(
        .DATA_T ( packet_descriptor_t ),
        .DEPTH  ( DESC_DEPTH )
    ) i_fifo_core (
        .clk     ( clk ),
        .arst_n  ( arst_n ),
        .wr_data ( desc ),
        .wr      ( desc_valid ),
        .wr_rdy  ( desc_rdy ),
        .rd_data ( fifo_desc ),
        .rd_ack  ( fifo_valid ),
        .rd      ( fifo_rdy )
    );

endmodule : packet_descriptor_fifo

//--- verification/packet_buffer_checker.sv
`timescale 1ns/1ps

module packet_buffer_checker
    import packet_pkg::*;
#(
    parameter int BUF_WORDS = 256
) (
    input logic                       clk,
    input logic                       arst_n,
    input beat_t                      in_beat,
    input logic                       in_valid,
    input logic                       in_rdy,
    input beat_t                      out_beat,
    input logic                       out_valid,
    input logic                       out_rdy,
    input logic                       buf_release,
    input logic [$clog2(BUF_WORDS):0] free_cnt
);

    int fail_cnt = 0;

    // A sender keeps valid and payload steady until the beat is taken.
    a_in_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && !in_rdy) |=> (in_valid && $stable(in_beat)))
        else begin
            $error("Input beat changed or in_valid dropped before the transfer.");
            fail_cnt++;
        end

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_rdy) |=> (out_valid && $stable(out_beat)))
        else begin
            $error("Output beat changed or out_valid dropped before the transfer.");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!out_valid && !in_rdy && !buf_release))
        else begin
            $error("out_valid, in_rdy or buffer release active during reset.");
            fail_cnt++;
        end

    // A released word was stored earlier, so the free count cannot already be full.
    a_release_stored: assert property (@(posedge clk) disable iff (!arst_n)
        buf_release |-> (int'(free_cnt) < BUF_WORDS))
        else begin
            $error("Buffer release fired while every buffer word was already free.");
            fail_cnt++;
        end

endmodule : packet_buffer_checker

bind packet_buffer packet_buffer_checker #(
    .BUF_WORDS ( BUF_WORDS )
) i_checker (
    .clk         ( clk ),
    .arst_n      ( arst_n ),
    .in_beat     ( in_beat ),
    .in_valid    ( in_valid ),
    .in_rdy      ( in_rdy ),
    .out_beat    ( out_beat ),
    .out_valid   ( out_valid ),
    .out_rdy     ( out_rdy ),
    .buf_release ( buf_release ),
    .free_cnt    ( i_ingress.free_cnt )
);

//--- verification/packet_buffer_tb.sv
`timescale 1ns/1ps

module packet_buffer_tb
    import packet_pkg::*;
();

    localparam int BUF_WORDS  = 256;
    localparam int DESC_DEPTH = 8;
    localparam int MAX_BEATS  = 64;

    logic  clk = 1'b0;
    logic  arst_n;
    beat_t in_beat;
    logic  in_valid;
    logic  in_rdy;
    beat_t out_beat;
    logic  out_valid;
    logic  out_rdy;

    // Expected output beats, oldest first.
    beat_t exp_q [$];
    beat_t exp_beat;
    string cur_test;
    int    rdy_mode;
    int    mode_now;
    int    cycle_cnt;
    int    total_beats;
    int    stall_run;
    int    max_stall;

    packet_buffer #(
        .BUF_WORDS  ( BUF_WORDS ),
        .DESC_DEPTH ( DESC_DEPTH ),
        .MAX_BEATS  ( MAX_BEATS )
    ) dut0 (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .in_beat   ( in_beat ),
        .in_valid  ( in_valid ),
        .in_rdy    ( in_rdy ),
        .out_beat  ( out_beat ),
        .out_valid ( out_valid ),
        .out_rdy   ( out_rdy )
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_data(input string test, input data_t exp, input data_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s data: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic compare_meta(input string test, input meta_t exp, input meta_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s meta: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic compare_flag(input string test, input string what, input logic exp,
                                input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s %s: expected %b, actual %b",
                                     test, what, exp, act));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Holds the beat on the input until a cycle in which in_rdy was high.
    task automatic send_beat(input beat_t b);
        logic taken;
        in_beat  = b;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_rdy;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_packet(input int len);
        beat_t beats [$];
        beat_t b;
        beat_t e;
        meta_t first_meta;
        logic  err_any;
        int    kept;
        for (int i = 0; i < len; i++) begin
            b.data = $urandom();
            b.meta = meta_t'($urandom());
            b.last = (i == len - 1);
            b.err  = ($urandom_range(15) == 0);
            beats.push_back(b);
        end
        // Meta comes from the first beat, err covers every beat and truncation,
        // and only the first MAX_BEATS beats are stored.
        first_meta = beats[0].meta;
        err_any    = (len > MAX_BEATS);
        foreach (beats[i]) begin
            err_any = err_any | beats[i].err;
        end
        kept = (len > MAX_BEATS) ? MAX_BEATS : len;
        for (int i = 0; i < kept; i++) begin
            e.data = beats[i].data;
            e.meta = first_meta;
            e.last = (i == kept - 1);
            e.err  = err_any;
            exp_q.push_back(e);
        end
        total_beats += len;
        foreach (beats[i]) begin
            send_beat(beats[i]);
        end
        in_valid = 1'b0;
    endtask

    task automatic run_packets(input int count, input int min_len, input int max_len,
                               input int gap_max);
        for (int p = 0; p < count; p++) begin
            send_packet($urandom_range(max_len, min_len));
            idle_cycles($urandom_range(gap_max, 0));
        end
    endtask

    // Keeps out_rdy low for a while, then checks that the input side stalled.
    task automatic hold_output(input int cycles, input int min_stall);
        idle_cycles(cycles);
        if (max_stall < min_stall) begin
            report_failure($sformatf("%s: input was never stalled for %0d cycles in a row.",
                                     cur_test, min_stall));
        end
        rdy_mode = 0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Mode 0 keeps out_rdy high, mode 1 toggles it at random, mode 2 holds it low.
    always @(posedge clk) begin
        mode_now = rdy_mode;
        #2;
        case (mode_now)
            0:       out_rdy = 1'b1;
            1:       out_rdy = 1'($urandom_range(1));
            default: out_rdy = 1'b0;
        endcase
    end

    // Outputs and in_rdy are stable at the falling edge, one half period from any change.
    always @(negedge clk) begin
        if (dut0.i_checker.fail_cnt != 0) begin
            report_failure("A bound assertion on the DUT handshakes failed.");
        end
        if (arst_n && out_valid && out_rdy) begin
            if (exp_q.size() == 0) begin
                report_failure("An output beat arrived while no packet was expected.");
            end else begin
                exp_beat = exp_q.pop_front();
                compare_data(cur_test, exp_beat.data, out_beat.data);
                compare_meta(cur_test, exp_beat.meta, out_beat.meta);
                compare_flag(cur_test, "last", exp_beat.last, out_beat.last);
                compare_flag(cur_test, "err", exp_beat.err, out_beat.err);
            end
        end
        if (arst_n && in_valid && !in_rdy) begin
            stall_run++;
            if (stall_run > max_stall) begin
                max_stall = stall_run;
            end
        end else begin
            stall_run = 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 20 * total_beats + 1000) begin
            report_failure($sformatf("Timeout after %0d cycles while running %s.",
                                     cycle_cnt, cur_test));
        end
    end

    initial begin
        void'($urandom(32'hca40));
        arst_n      = 1'b0;
        in_beat     = '0;
        in_valid    = 1'b0;
        out_rdy     = 1'b0;
        rdy_mode    = 0;
        cycle_cnt   = 0;
        total_beats = 0;
        stall_run   = 0;
        max_stall   = 0;
        cur_test    = "reset_idle";
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;

        repeat (20) begin
            @(negedge clk);
            compare_flag(cur_test, "out_valid", 1'b0, out_valid);
        end
        idle_cycles(1);

        cur_test = "single_packets";
        run_packets(30, 1, 20, 2);
        wait_drain();

        cur_test = "truncation";
        run_packets(4, MAX_BEATS + 1, 90, 1);
        wait_drain();

        cur_test = "backpressure";
        rdy_mode = 1;
        run_packets(30, 1, 20, 2);
        wait_drain();
        rdy_mode = 0;

        // Over 256 beats with the output blocked, so ingress runs out of space.
        cur_test  = "buffer_full";
        max_stall = 0;
        rdy_mode  = 2;
        fork
            run_packets(6, 48, MAX_BEATS, 0);
            hold_output(500, 100);
        join
        wait_drain();

        // Short packets overrun the descriptor FIFO while the output is blocked.
        cur_test  = "back_to_back";
        max_stall = 0;
        rdy_mode  = 2;
        fork
            run_packets(40, 1, 3, 0);
            hold_output(80, 20);
        join
        wait_drain();

        if (dut0.i_checker.fail_cnt != 0) begin
            report_failure("A bound assertion on the DUT handshakes failed.");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule : packet_buffer_tb

//--- verilog/packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer
    import packet_pkg::*;
#(
    parameter int BUF_WORDS  = 256,
    parameter int DESC_DEPTH = 8,
    parameter int MAX_BEATS  = 64
) (
    input  logic  clk,
    input  logic  arst_n,
    input  beat_t in_beat,
    input  logic  in_valid,
    output logic  in_rdy,
    output beat_t out_beat,
    output logic  out_valid,
    input  logic  out_rdy
);

    packet_descriptor_t desc;
    logic               desc_valid;
    logic               desc_rdy;
    packet_descriptor_t fifo_desc;
    logic               fifo_valid;
    logic               fifo_rdy;
    logic               wr_en;
    addr_t              wr_addr;
    data_t              wr_data;
    logic               rd_en;
    addr_t              rd_addr;
    data_t              rd_data;
    logic               buf_release;

    packet_ingress #(
        .BUF_WORDS ( BUF_WORDS ),
        .MAX_BEATS ( MAX_BEATS )
    ) i_ingress (
        .clk         ( clk ),
        .arst_n      ( arst_n ),
        .in_beat     ( in_beat ),
        .in_valid    ( in_valid ),
        .in_rdy      ( in_rdy ),
        .wr_en       ( wr_en ),
        .wr_addr     ( wr_addr ),
        .wr_data     ( wr_data ),
        .desc        ( desc ),
        .desc_valid  ( desc_valid ),
        .desc_rdy    ( desc_rdy ),
        .buf_release ( buf_release )
    );

    packet_descriptor_fifo #(
        .DESC_DEPTH ( DESC_DEPTH )
    ) i_desc_fifo (
        .clk        ( clk ),
        .arst_n     ( arst_n ),
        .desc       ( desc ),
        .desc_valid ( desc_valid ),
        .desc_rdy   ( desc_rdy ),
        .fifo_desc  ( fifo_desc ),
        .fifo_valid ( fifo_valid ),
        .fifo_rdy   ( fifo_rdy )
    );

    packet_buffer_mem #(
        .BUF_WORDS ( BUF_WORDS )
    ) i_mem (
        .clk     ( clk ),
        .wr_en   ( wr_en ),
        .wr_addr ( wr_addr ),
        .wr_data ( wr_data ),
        .rd_en   ( rd_en ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data )
    );

    packet_egress #(
        .BUF_WORDS ( BUF_WORDS )
    ) i_egress (
        .clk         ( clk ),
        .arst_n      ( arst_n ),
        .fifo_desc   ( fifo_desc ),
        .fifo_valid  ( fifo_valid ),
        .fifo_rdy    ( fifo_rdy ),
        .rd_en       ( rd_en ),
        .rd_addr     ( rd_addr ),
        .rd_data     ( rd_data ),
        .out_beat    ( out_beat ),
        .out_valid   ( out_valid ),
        .out_rdy     ( out_rdy ),
        .buf_release ( buf_release )
    );

endmodule : packet_buffer

//--- verilog/packet_buffer_mem.sv
`timescale 1ns/1ps

module packet_buffer_mem
    import packet_pkg::*;
#(
    parameter int BUF_WORDS = 256
) (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  logic  rd_en,
    input  addr_t rd_addr,
    output data_t rd_data
);

    localparam int AW = $clog2(BUF_WORDS);

    data_t words [BUF_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            words[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // The read register only updates on rd_en, so it holds its word during a stall.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= words[rd_addr[AW-1:0]];
        end
    end

endmodule : packet_buffer_mem

//--- verilog/packet_egress.sv
`timescale 1ns/1ps

module packet_egress
    import packet_pkg::*;
#(
    parameter int BUF_WORDS = 256
) (
    input  logic               clk,
    input  logic               arst_n,
    input  packet_descriptor_t fifo_desc,
    input  logic               fifo_valid,
    output logic               fifo_rdy,
    output logic               rd_en,
    output addr_t              rd_addr,
    input  data_t              rd_data,
    output beat_t              out_beat,
    output logic               out_valid,
    input  logic               out_rdy,
    output logic               buf_release
);

    localparam addr_t ADDR_MASK = addr_t'(BUF_WORDS - 1);

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t state;
    addr_t  rd_ptr;
    size_t  remaining;
    meta_t  meta_q;
    logic   err_q;

    // Sideband that follows each read through the memory output stage.
    logic  mem_vld;
    meta_t mem_meta;
    logic  mem_last;
    logic  mem_err;
    beat_t mem_beat;

    beat_t skid_beat;
    logic  skid_vld;

    logic out_free;
    logic mem_take;
    logic skid_load;

    assign fifo_rdy    = (state == ST_IDLE);
    assign rd_addr     = rd_ptr;
    assign buf_release = out_valid && out_rdy;

    assign mem_beat = '{data: rd_data, meta: mem_meta, last: mem_last, err: mem_err};

    assign out_free = !out_valid || out_rdy;
    assign mem_take = mem_vld && (out_free || !skid_vld);

    // The memory beat goes to the skid register when the output is busy,
    // or when the skid register is itself moving into the output.
    assign skid_load = mem_vld && (skid_vld ? out_free : !out_free);

    // A new read is only issued when the beat now in the memory stage is sure to move on.
    assign rd_en = (state == ST_STREAM) && !(mem_vld && skid_vld);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            rd_ptr    <= '0;
            remaining <= '0;
            mem_vld   <= 1'b0;
            skid_vld  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fifo_valid) begin
                        state     <= ST_STREAM;
                        rd_ptr    <= fifo_desc.addr;
                        remaining <= fifo_desc.size;
                    end
                end
                ST_STREAM: begin
                    if (rd_en) begin
                        rd_ptr    <= (rd_ptr + addr_t'(1)) & ADDR_MASK;
                        remaining <= remaining - size_t'(1);
                        if (remaining == size_t'(1)) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase

            mem_vld <= rd_en || (mem_vld && !mem_take);

            if (out_free) begin
                out_valid <= skid_vld || mem_vld;
                skid_vld  <= skid_vld && mem_vld;
            end else if (!skid_vld) begin
                skid_vld <= mem_vld;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rdy && fifo_valid) begin
            meta_q <= fifo_desc.meta;
            err_q  <= fifo_desc.err;
        end
        if (rd_en) begin
            mem_meta <= meta_q;
            mem_err  <= err_q;
            mem_last <= (remaining == size_t'(1));
        end
        if (skid_load) begin
            skid_beat <= mem_beat;
        end
        // The skid register holds the older beat, so it has priority for the output.
        if (out_free) begin
            out_beat <= skid_vld ? skid_beat : mem_beat;
        end
    end

endmodule : packet_egress

//--- verilog/packet_ingress.sv
`timescale 1ns/1ps

module packet_ingress
    import packet_pkg::*;
#(
    parameter int BUF_WORDS = 256,
    parameter int MAX_BEATS = 64
) (
    input  logic               clk,
    input  logic               arst_n,
    input  beat_t              in_beat,
    input  logic               in_valid,
    output logic               in_rdy,
    output logic               wr_en,
    output addr_t              wr_addr,
    output data_t              wr_data,
    output packet_descriptor_t desc,
    output logic               desc_valid,
    input  logic               desc_rdy,
    input  logic               buf_release
);

    localparam int    CNT_W     = $clog2(BUF_WORDS) + 1;
    localparam addr_t ADDR_MASK = addr_t'(BUF_WORDS - 1);

    addr_t            wr_ptr;
    logic [CNT_W-1:0] free_cnt;
    addr_t            start_addr;
    size_t            size_cnt;
    logic             err_acc;
    meta_t            meta_q;
    logic             started;

    logic  first_beat;
    logic  trunc;
    logic  accept;
    logic  store;
    addr_t pkt_addr;
    size_t pkt_size;
    meta_t pkt_meta;
    logic  pkt_err;

    // Every packet stores at least one beat, so a zero count marks the first beat.
    assign first_beat = (size_cnt == '0);
    assign trunc      = (size_cnt == size_t'(MAX_BEATS));

    // Beats past MAX_BEATS are dropped, so they do not need free space.
    // The input stays closed until the first clock edge after reset.
    assign in_rdy = started && !desc_valid && (trunc || (free_cnt != '0));
    assign accept = in_valid && in_rdy;
    assign store  = accept && !trunc;

    assign wr_en   = store;
    assign wr_addr = wr_ptr;
    assign wr_data = in_beat.data;

    // Descriptor fields as they stand after the beat currently on the input.
    assign pkt_addr = first_beat ? wr_ptr : start_addr;
    assign pkt_meta = first_beat ? in_beat.meta : meta_q;
    assign pkt_size = store ? size_cnt + size_t'(1) : size_cnt;
    assign pkt_err  = err_acc | in_beat.err | trunc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            free_cnt   <= CNT_W'(BUF_WORDS);
            size_cnt   <= '0;
            err_acc    <= 1'b0;
            desc_valid <= 1'b0;
            started    <= 1'b0;
        end else begin
            started <= 1'b1;
            if (store) begin
                wr_ptr <= (wr_ptr + addr_t'(1)) & ADDR_MASK;
            end
            if (accept) begin
                if (in_beat.last) begin
                    size_cnt <= '0;
                    err_acc  <= 1'b0;
                end else begin
                    size_cnt <= pkt_size;
                    err_acc  <= pkt_err;
                end
            end
            // in_rdy is low while a descriptor is pending, so set and clear never meet.
            if (accept && in_beat.last) begin
                desc_valid <= 1'b1;
            end else if (desc_rdy) begin
                desc_valid <= 1'b0;
            end
            free_cnt <= free_cnt + CNT_W'(buf_release) - CNT_W'(store);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && first_beat) begin
            start_addr <= wr_ptr;
            meta_q     <= in_beat.meta;
        end
        if (accept && in_beat.last) begin
            desc.addr <= pkt_addr;
            desc.size <= pkt_size;
            desc.meta <= pkt_meta;
            desc.err  <= pkt_err;
        end
    end

endmodule : packet_ingress
